// ==== Makefile ====
# Verilator build and run of the register file testbench.

VERILATOR ?= verilator
TOP       ?= tb_gpr
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= \*\* PASS \*\*

.PHONY: sim clean

# The run passes only when the log holds the pass line on its own.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -x '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cr_iu_oper_gpr.sv ====
module cr_iu_oper_gpr (
  input  logic                 forever_cpuclk,
  input  logic                 rst,
  input  logic                 gpr_clear,
  input  gpr_pkg::gpr_wr_req_t wr_req,
  input  gpr_pkg::gpr_idx_t    rd_index0,
  input  gpr_pkg::gpr_idx_t    rd_index1,
  output gpr_pkg::gpr_data_t   rd_data0,
  output gpr_pkg::gpr_data_t   rd_data1
);

  gpr_pkg::gpr_wr_t   wr;    // Decoded write command.
  gpr_pkg::gpr_file_t regs;  // Register contents.

  gpr_write_decode i_write_decode (
    .rst       (rst),
    .gpr_clear (gpr_clear),
    .wr_req    (wr_req),
    .wr        (wr)
  );

  gpr_bank i_bank (
    .forever_cpuclk (forever_cpuclk),
    .wr             (wr),
    .regs           (regs)
  );

  // Reads see the bank directly, so a same-cycle write is not bypassed.
  gpr_read_port i_rd_port0 (
    .regs     (regs),
    .rd_index (rd_index0),
    .rd_data  (rd_data0)
  );

  gpr_read_port i_rd_port1 (
    .regs     (regs),
    .rd_index (rd_index1),
    .rd_data  (rd_data1)
  );

endmodule

// ==== gpr_bank.sv ====
module gpr_bank (
  input  logic               forever_cpuclk,
  input  gpr_pkg::gpr_wr_t   wr,
  output gpr_pkg::gpr_file_t regs
);

  // Storage for x1 to x15 only.
  gpr_pkg::gpr_data_t gpr_q [1:gpr_pkg::GPR_NUM-1];

  always_ff @(posedge forever_cpuclk)
  begin
    for (int i = 1; i < gpr_pkg::GPR_NUM; i++)
    begin
      if (wr.wen[i])
      begin
        gpr_q[i] <= wr.data;  // Clears also arrive here as zero writes.
      end
    end
  end

  always_comb
  begin
    regs[0] = '0;  // x0 reads zero.
    for (int i = 1; i < gpr_pkg::GPR_NUM; i++)
    begin
      regs[i] = gpr_q[i];
    end
  end

endmodule

// ==== gpr_pkg.sv ====
package gpr_pkg;

  localparam int XLEN    = 32;  // Register width.
  localparam int GPR_NUM = 16;  // Architectural registers x0 to x15.
  localparam int IDX_W   = 5;   // Index width, 16 to 31 read as zero.
  localparam int SP_IDX  = 2;   // Stack pointer.

  typedef logic [XLEN-1:0]  gpr_data_t;
  typedef logic [IDX_W-1:0] gpr_idx_t;

  // Write request as it arrives from the pipeline.
  typedef struct packed {
    logic      wen;
    gpr_idx_t  index;
    gpr_data_t data;
  } gpr_wr_req_t;

  // One write enable per register, bit 0 unused.
  typedef logic [GPR_NUM-1:0] gpr_wen_t;

  // Decoded write command into the bank.
  typedef struct packed {
    gpr_wen_t  wen;
    gpr_data_t data;
  } gpr_wr_t;

  // All register contents as seen by the read ports.
  typedef gpr_data_t [GPR_NUM-1:0] gpr_file_t;

endpackage

// ==== gpr_props.sv ====
module gpr_props (
  input logic                 forever_cpuclk,
  input logic                 rst,
  input logic                 gpr_clear,
  input gpr_pkg::gpr_wr_req_t wr_req,
  input gpr_pkg::gpr_wr_t     wr
);

  logic sp_write;  // Request targets the stack pointer.

  assign sp_write = wr_req.wen && (wr_req.index == gpr_pkg::gpr_idx_t'(gpr_pkg::SP_IDX));

  // Full reset writes zero into x1 to x15.
  rst_clears_all: assert property (@(posedge forever_cpuclk)
    rst |-> ((&wr.wen[gpr_pkg::GPR_NUM-1:1]) && (wr.data == '0)))
    else $error("Reset did not force a zero write into every register");

  no_x0_write: assert property (@(posedge forever_cpuclk)
    !wr.wen[0])
    else $error("Write enable for x0 is set");

  single_write: assert property (@(posedge forever_cpuclk)
    (!rst && !gpr_clear) |-> $onehot0(wr.wen))
    else $error("More than one write enable is set outside reset");

  // Split clear only touches x2 when the request itself writes x2.
  sp_follows_request: assert property (@(posedge forever_cpuclk)
    (gpr_clear && !rst) |-> (wr.wen[gpr_pkg::SP_IDX] == sp_write))
    else $error("Stack pointer enable does not follow the request during clear");

endmodule

// Decoder ports sampled on the register file clock.
bind cr_iu_oper_gpr gpr_props i_props (
  .forever_cpuclk (forever_cpuclk),
  .rst            (rst),
  .gpr_clear      (gpr_clear),
  .wr_req         (wr_req),
  .wr             (wr)
);

// ==== gpr_read_port.sv ====
module gpr_read_port (
  input  gpr_pkg::gpr_file_t regs,
  input  gpr_pkg::gpr_idx_t  rd_index,
  output gpr_pkg::gpr_data_t rd_data
);

  always_comb
  begin
    case (rd_index)
      5'd0:    rd_data = regs[0];
      5'd1:    rd_data = regs[1];
      5'd2:    rd_data = regs[2];  // Stack pointer.
      5'd3:    rd_data = regs[3];
      5'd4:    rd_data = regs[4];
      5'd5:    rd_data = regs[5];
      5'd6:    rd_data = regs[6];
      5'd7:    rd_data = regs[7];
      5'd8:    rd_data = regs[8];
      5'd9:    rd_data = regs[9];
      5'd10:   rd_data = regs[10];
      5'd11:   rd_data = regs[11];
      5'd12:   rd_data = regs[12];
      5'd13:   rd_data = regs[13];
      5'd14:   rd_data = regs[14];
      5'd15:   rd_data = regs[15];
      default: rd_data = '0;  // Upper half of the index space.
    endcase
  end

endmodule

// ==== gpr_write_decode.sv ====
module gpr_write_decode (
  input  logic                 rst,
  input  logic                 gpr_clear,
  input  gpr_pkg::gpr_wr_req_t wr_req,
  output gpr_pkg::gpr_wr_t     wr
);

  logic              gpr_rst;    // Clears x1 and x3 to x15.
  logic              sp_rst;     // Clears the stack pointer only.
  gpr_pkg::gpr_wen_t reg_sel;    // One-hot decode of the write index.
  gpr_pkg::gpr_wen_t user_wen;   // Explicit write enables.
  gpr_pkg::gpr_wen_t force_wen;  // Reset driven write enables.

  // The split clear leaves x2 alone, full reset takes everything.
  assign gpr_rst = rst | gpr_clear;
  assign sp_rst  = rst;

  always_comb
  begin
    reg_sel = '0;
    case (wr_req.index)
      5'd1:    reg_sel[1]  = 1'b1;
      5'd2:    reg_sel[2]  = 1'b1;
      5'd3:    reg_sel[3]  = 1'b1;
      5'd4:    reg_sel[4]  = 1'b1;
      5'd5:    reg_sel[5]  = 1'b1;
      5'd6:    reg_sel[6]  = 1'b1;
      5'd7:    reg_sel[7]  = 1'b1;
      5'd8:    reg_sel[8]  = 1'b1;
      5'd9:    reg_sel[9]  = 1'b1;
      5'd10:   reg_sel[10] = 1'b1;
      5'd11:   reg_sel[11] = 1'b1;
      5'd12:   reg_sel[12] = 1'b1;
      5'd13:   reg_sel[13] = 1'b1;
      5'd14:   reg_sel[14] = 1'b1;
      5'd15:   reg_sel[15] = 1'b1;
      default: reg_sel     = '0;  // x0 and 16 to 31 write nothing.
    endcase
  end

  assign user_wen = reg_sel & {gpr_pkg::GPR_NUM{wr_req.wen}};

  always_comb
  begin
    force_wen                  = {gpr_pkg::GPR_NUM{gpr_rst}};
    force_wen[gpr_pkg::SP_IDX] = sp_rst;  // Own reset domain.
    force_wen[0]               = 1'b0;    // x0 has no storage.
  end

  // A forced write stores zero, and so does an x2 write during the clear.
  assign wr.wen  = user_wen | force_wen;
  assign wr.data = gpr_rst ? '0 : wr_req.data;

endmodule

// ==== tb_gpr.sv ====
module tb_gpr;

  localparam int HALF_PERIOD   = 4;
  localparam int RESET_CYCLES  = 4;
  localparam int RANDOM_CYCLES = 400;
  localparam int WTR_ROUNDS    = 20;
  localparam int MAX_CYCLES    = 2000;

  logic                 forever_cpuclk = 1'b0;
  logic                 rst;
  logic                 gpr_clear;
  gpr_pkg::gpr_wr_req_t wr_req;
  gpr_pkg::gpr_idx_t    rd_index0;
  gpr_pkg::gpr_idx_t    rd_index1;
  gpr_pkg::gpr_data_t   rd_data0;
  gpr_pkg::gpr_data_t   rd_data1;

  gpr_pkg::gpr_data_t   model [gpr_pkg::GPR_NUM];  // Expected register contents.
  gpr_pkg::gpr_idx_t    sp_idx;
  int                   seed;
  int                   errors;
  int                   checks;

  cr_iu_oper_gpr i_dut (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .gpr_clear      (gpr_clear),
    .wr_req         (wr_req),
    .rd_index0      (rd_index0),
    .rd_index1      (rd_index1),
    .rd_data0       (rd_data0),
    .rd_data1       (rd_data1)
  );

  always #HALF_PERIOD forever_cpuclk = ~forever_cpuclk;

  task automatic check(input string name, input gpr_pkg::gpr_data_t expected,
                       input gpr_pkg::gpr_data_t actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // x0 and the upper half of the index space have no storage.
  function automatic gpr_pkg::gpr_data_t model_read(input gpr_pkg::gpr_idx_t idx);
    gpr_pkg::gpr_data_t value;
    value = '0;
    if (idx != '0 && idx[gpr_pkg::IDX_W-1] == 1'b0)
    begin
      value = model[idx[3:0]];
    end
    return value;
  endfunction

  // What the next rising edge does to the registers.
  task automatic update_model(input logic r, input logic c, input gpr_pkg::gpr_wr_req_t req);
    if (r)
    begin
      for (int i = 1; i < gpr_pkg::GPR_NUM; i++)
      begin
        model[i[3:0]] = '0;
      end
    end
    else if (c)
    begin
      for (int i = 1; i < gpr_pkg::GPR_NUM; i++)
      begin
        if (i != gpr_pkg::SP_IDX)
        begin
          model[i[3:0]] = '0;
        end
      end
      if (req.wen && int'(req.index) == gpr_pkg::SP_IDX)
      begin
        model[req.index[3:0]] = '0;  // Write data is masked during clear.
      end
    end
    else if (req.wen && req.index != '0 && req.index[gpr_pkg::IDX_W-1] == 1'b0)
    begin
      model[req.index[3:0]] = req.data;
    end
  endtask

  function automatic gpr_pkg::gpr_wr_req_t make_req(input logic wen,
                                                    input gpr_pkg::gpr_idx_t index,
                                                    input gpr_pkg::gpr_data_t data);
    gpr_pkg::gpr_wr_req_t req;
    req.wen   = wen;
    req.index = index;
    req.data  = data;
    return req;
  endfunction

  // Mostly real registers with the empty upper half now and then.
  function automatic gpr_pkg::gpr_idx_t random_index();
    logic [31:0] rnd;
    rnd = $random(seed);
    if (rnd[7:5] == 3'b000)
    begin
      return rnd[4:0];
    end
    return {1'b0, rnd[3:0]};
  endfunction

  function automatic gpr_pkg::gpr_idx_t random_reg_index();
    logic [31:0] rnd;
    rnd = $random(seed);
    if (rnd[3:0] == 4'd0)
    begin
      return 5'd1;
    end
    return {1'b0, rnd[3:0]};
  endfunction

  // Drives on the falling edge and compares before the model takes the rising edge.
  task automatic run_cycle(input string name, input logic r, input logic c,
                           input gpr_pkg::gpr_wr_req_t req, input gpr_pkg::gpr_idx_t ri0,
                           input gpr_pkg::gpr_idx_t ri1, input bit check_reads);
    @(negedge forever_cpuclk);
    rst       = r;
    gpr_clear = c;
    wr_req    = req;
    rd_index0 = ri0;
    rd_index1 = ri1;
    #(HALF_PERIOD / 2);
    if (check_reads)
    begin
      check(name, model_read(ri0), rd_data0);
      check(name, model_read(ri1), rd_data1);
    end
    update_model(r, c, req);
  endtask

  task automatic test_reset();
    // The cycle before the first falling edge is the first reset cycle.
    for (int i = 1; i < RESET_CYCLES; i++)
    begin
      run_cycle("reset", 1'b1, 1'b0, make_req(1'b1, random_index(), $random(seed)),
                '0, '0, 1'b0);
    end
    for (int i = 0; i < (1 << gpr_pkg::IDX_W); i++)
    begin
      run_cycle("reset_read", 1'b0, 1'b0, '0, gpr_pkg::gpr_idx_t'(i),
                gpr_pkg::gpr_idx_t'(31 - i), 1'b1);
      check("reset_zero", '0, rd_data0);
    end
  endtask

  task automatic test_random();
    logic [31:0]          rnd;
    gpr_pkg::gpr_idx_t    widx;
    gpr_pkg::gpr_data_t   wdata;
    gpr_pkg::gpr_idx_t    ri0;
    gpr_pkg::gpr_idx_t    ri1;
    for (int n = 0; n < RANDOM_CYCLES; n++)
    begin
      rnd   = $random(seed);
      widx  = random_index();
      wdata = $random(seed);
      ri0   = random_index();
      ri1   = random_index();
      run_cycle("random", 1'b0, rnd[7:2] == 6'd0, make_req(rnd[0] | rnd[1], widx, wdata),
                ri0, ri1, 1'b1);
      if (ri0 == '0 || ri0[gpr_pkg::IDX_W-1])
      begin
        check("random_zero", '0, rd_data0);
      end
    end
  endtask

  task automatic test_partial_clear();
    gpr_pkg::gpr_data_t sp_before;
    for (int i = 1; i < gpr_pkg::GPR_NUM; i++)
    begin
      run_cycle("clear_fill", 1'b0, 1'b0,
                make_req(1'b1, gpr_pkg::gpr_idx_t'(i), $random(seed)), '0, '0, 1'b1);
    end
    sp_before = model_read(sp_idx);
    run_cycle("clear_pulse", 1'b0, 1'b1, '0, '0, '0, 1'b1);
    for (int i = 0; i < gpr_pkg::GPR_NUM; i += 2)
    begin
      run_cycle("clear_read", 1'b0, 1'b0, '0, gpr_pkg::gpr_idx_t'(i),
                gpr_pkg::gpr_idx_t'(i + 1), 1'b1);
    end
    run_cycle("clear_sp_read", 1'b0, 1'b0, '0, sp_idx, sp_idx, 1'b1);
    check("clear_sp_kept", sp_before, rd_data0);
  endtask

  task automatic test_sp_clear();
    logic [31:0] rnd;
    for (int n = 0; n < 4; n++)
    begin
      rnd = $random(seed);
      run_cycle("sp_clear_set", 1'b0, 1'b0, make_req(1'b1, sp_idx, rnd | 32'h1),
                '0, '0, 1'b1);
      run_cycle("sp_clear_write", 1'b0, 1'b1, make_req(1'b1, sp_idx, rnd ^ 32'hdead_beef),
                sp_idx, sp_idx, 1'b1);
      run_cycle("sp_clear_read", 1'b0, 1'b0, '0, sp_idx, sp_idx, 1'b1);
      check("sp_clear_zero", '0, rd_data1);
    end
  endtask

  task automatic test_write_then_read();
    gpr_pkg::gpr_idx_t  idx;
    gpr_pkg::gpr_data_t data;
    gpr_pkg::gpr_data_t old;
    for (int n = 0; n < WTR_ROUNDS; n++)
    begin
      idx  = random_reg_index();
      data = $random(seed);
      old  = model_read(idx);
      run_cycle("wtr_same_cycle", 1'b0, 1'b0, make_req(1'b1, idx, data), idx, idx, 1'b1);
      check("wtr_same_cycle_old", old, rd_data0);
      run_cycle("wtr_next_cycle", 1'b0, 1'b0, '0, idx, idx, 1'b1);
      check("wtr_next_cycle_new", data, rd_data1);
    end
  endtask

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge forever_cpuclk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    seed      = 32'ha2b48247;
    errors    = 0;
    checks    = 0;
    sp_idx    = gpr_pkg::gpr_idx_t'(gpr_pkg::SP_IDX);
    rst       = 1'b1;
    gpr_clear = 1'b0;
    wr_req    = '0;
    rd_index0 = '0;
    rd_index1 = '0;

    test_reset();
    test_random();
    test_partial_clear();
    test_sp_clear();
    test_write_then_read();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
gpr_pkg.sv
gpr_write_decode.sv
gpr_bank.sv
gpr_read_port.sv
cr_iu_oper_gpr.sv
gpr_props.sv
tb_gpr.sv
